/* tb.f */
+incdir+verification
verilog/posit_fmt_pkg.sv
verilog/pipe_pkg.sv
verilog/posit_decode.sv
verilog/operand_align.sv
verilog/mantissa_norm.sv
verilog/posit_encode.sv
verilog/pipe_control.sv
verilog/posit_adder.sv
verification/tb_posit_adder.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the posit adder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_posit_adder \
    -f tb.f -o sim_posit_adder

output=$(./obj_dir/sim_posit_adder)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "simulation did not pass"
exit 1

/* verification/posit_model.svh */
`ifndef POSIT_MODEL_SVH
`define POSIT_MODEL_SVH

// Exact values are scaled by 2^SCALE_BITS so minpos reads as one
localparam int SCALE_BITS = (1 << ES) * (N - 2);
localparam int TABLE_SIZE = (1 << N) - 1;
localparam logic [N-1:0] NAR_CODE = {1'b1, {(N-1){1'b0}}};

// Every code except NaR, ascending by value
longint       table_val[TABLE_SIZE];
logic [N-1:0] table_code[TABLE_SIZE];

int unsigned  lcg_state = 95;

// Exact value of one posit, NaR reads as zero
function automatic longint posit_value(input logic [N-1:0] code);
    logic [N-1:0] body;
    int           run;
    int           k;
    int           pos;
    int           expo;
    int           frac_bits;
    longint       mant;
    longint       value;
    if (code == '0 || code == NAR_CODE)
    begin
        return 0;
    end
    body = code[N-1] ? -code : code;
    // Regime run starts just below the sign
    run = 1;
    while (run < N - 1)
    begin
        if (body[N-2-run] != body[N-2])
        begin
            break;
        end
        run++;
    end
    k = body[N-2] ? run - 1 : -run;
    // Skip the terminator; exponent bits past the end read as zero
    pos = N - 3 - run;
    expo = 0;
    for (int i = 0; i < ES; i++)
    begin
        expo = 2 * expo + ((pos >= 0) ? int'(body[pos]) : 0);
        pos--;
    end
    frac_bits = (pos >= 0) ? pos + 1 : 0;
    // Hidden one ahead of the fraction
    mant = 1;
    for (int i = pos; i >= 0; i--)
    begin
        mant = 2 * mant + longint'(body[i]);
    end
    value = mant <<< (k * (1 << ES) + expo + SCALE_BITS - frac_bits);
    return code[N-1] ? -value : value;
endfunction

// Posits order like two's complement integers, so signed code order is sorted
function automatic void fill_table();
    logic [N-1:0] code;
    for (int i = 0; i < TABLE_SIZE; i++)
    begin
        code = N'(i + (1 << (N - 1)) + 1);
        table_code[i] = code;
        table_val[i] = posit_value(code);
    end
endfunction

// Codes just below and above an exact sum, equal when it is representable
// Sums past either end clamp to the largest posit of that sign
function automatic void bracket(input longint sum, output logic [N-1:0] lo,
                                output logic [N-1:0] hi);
    int idx;
    if (sum >= table_val[TABLE_SIZE-1])
    begin
        lo = table_code[TABLE_SIZE-1];
        hi = lo;
    end
    else if (sum <= table_val[0])
    begin
        lo = table_code[0];
        hi = lo;
    end
    else
    begin
        idx = 0;
        while (table_val[idx+1] <= sum)
        begin
            idx++;
        end
        lo = table_code[idx];
        hi = (table_val[idx] == sum) ? lo : table_code[idx+1];
    end
endfunction

// LCG step, upper half carries the useful bits
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

`endif

/* verification/tb_posit_adder.sv */
`timescale 1ns/100ps

module tb_posit_adder;

    import pipe_pkg::*;

    localparam int N = 8;
    localparam int ES = 1;

    logic         aclk;
    logic         rst_i;
    logic         start_i;
    logic [N-1:0] operand_a_i;
    logic [N-1:0] operand_b_i;
    logic [N-1:0] result_o;
    logic         inf_o;
    logic         zero_o;
    logic         done_o;

    // Scoreboard, one entry per start, oldest first
    logic [N-1:0] lo_q[$];
    logic [N-1:0] hi_q[$];
    logic         inf_q[$];
    logic         zero_q[$];
    int           edge_q[$];

    int edge_count = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_errors = 0;
    int test_checks = 0;

    `include "posit_model.svh"

    posit_adder #(
        .N(N),
        .ES(ES)
    ) dut_i (
        .aclk(aclk),
        .rst_i(rst_i),
        .start_i(start_i),
        .operand_a_i(operand_a_i),
        .operand_b_i(operand_b_i),
        .result_o(result_o),
        .inf_o(inf_o),
        .zero_o(zero_o),
        .done_o(done_o)
    );

    initial
    begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // Rising edges seen so far, stable at the falling edge
    always @(posedge aclk)
    begin
        edge_count <= edge_count + 1;
    end

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // Outputs only move on rising edges, so the falling edge is a safe sample point
    task automatic check_outputs();
        logic [N-1:0] lo;
        logic [N-1:0] hi;
        int           start_edge;
        if (done_o !== 1'b1)
        begin
            // Idle slots carry no flags and a cleared result
            compare("idle result, done, inf, zero", {result_o, done_o, inf_o, zero_o}, 0);
        end
        else if (lo_q.size() == 0)
        begin
            errors++;
            $display("ERROR at %0t: done pulse with no start outstanding", $time);
        end
        else
        begin
            lo = lo_q.pop_front();
            hi = hi_q.pop_front();
            start_edge = edge_q.pop_front();
            // Sampling edge is stage 1, the output register is the last stage
            compare("done edge", edge_count, start_edge + PIPE_DEPTH - 1);
            compare("inf_o", inf_o, inf_q.pop_front());
            compare("zero_o", zero_o, zero_q.pop_front());
            // Truncation may land on either neighbour of an inexact sum
            if (lo === hi)
            begin
                compare("result_o", result_o, lo);
            end
            else
            begin
                compare($sformatf("result_o %0d within %0d..%0d", result_o, lo, hi),
                        (result_o === lo) || (result_o === hi), 1);
            end
        end
    endtask

    task automatic push_expected(input logic [N-1:0] a, input logic [N-1:0] b);
        logic [N-1:0] lo;
        logic [N-1:0] hi;
        if (a == NAR_CODE || b == NAR_CODE)
        begin
            lo = NAR_CODE;
            hi = NAR_CODE;
        end
        else if (a == '0 && b == '0)
        begin
            lo = '0;
            hi = '0;
        end
        else
        begin
            bracket(posit_value(a) + posit_value(b), lo, hi);
        end
        lo_q.push_back(lo);
        hi_q.push_back(hi);
        inf_q.push_back(a == NAR_CODE || b == NAR_CODE);
        zero_q.push_back(a == '0 && b == '0);
        // Taken at the next rising edge
        edge_q.push_back(edge_count + 1);
    endtask

    // One clock: check what came out, then drive the next inputs
    task automatic drive_cycle(input logic start, input logic [N-1:0] a,
                               input logic [N-1:0] b);
        @(negedge aclk);
        check_outputs();
        start_i = start;
        operand_a_i = a;
        operand_b_i = b;
        if (start)
        begin
            push_expected(a, b);
        end
    endtask

    task automatic wait_for_results();
        int waited;
        waited = 0;
        while (lo_q.size() != 0 && waited < 4 * PIPE_DEPTH)
        begin
            drive_cycle(1'b0, '0, '0);
            waited++;
        end
        if (lo_q.size() != 0)
        begin
            errors++;
            $display("Timeout: %0d results never came back", lo_q.size());
            lo_q.delete();
            hi_q.delete();
            inf_q.delete();
            zero_q.delete();
            edge_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        wait_for_results();
        tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    initial
    begin
        logic [N-1:0] a;
        logic [N-1:0] b;
        int           gap;
        rst_i = 1'b1;
        start_i = 1'b0;
        operand_a_i = '0;
        operand_b_i = '0;
        fill_table();
        repeat (2) @(negedge aclk);
        rst_i = 1'b0;

        // NaR wins against anything
        drive_cycle(1'b1, NAR_CODE, '0);
        drive_cycle(1'b1, '0, NAR_CODE);
        drive_cycle(1'b1, NAR_CODE, NAR_CODE);
        for (int i = 0; i < 8; i++)
        begin
            b = N'(lcg_next());
            drive_cycle(1'b1, NAR_CODE, b);
            drive_cycle(1'b1, b, NAR_CODE);
        end
        end_test("nar");

        // Both zero, then zero on one side
        drive_cycle(1'b1, '0, '0);
        for (int i = 0; i < 8; i++)
        begin
            a = N'(lcg_next());
            drive_cycle(1'b1, '0, a);
            drive_cycle(1'b1, a, '0);
        end
        end_test("zero");

        // Every code against its own negation
        for (int i = 1; i < (1 << N); i++)
        begin
            a = N'(i);
            if (a != NAR_CODE)
            begin
                drive_cycle(1'b1, a, -a);
            end
        end
        end_test("negate");

        // Back to back
        for (int i = 0; i < 400; i++)
        begin
            drive_cycle(1'b1, N'(lcg_next()), N'(lcg_next()));
        end
        end_test("random");

        // Idle gaps of 0 to 3 cycles between starts
        for (int i = 0; i < 200; i++)
        begin
            gap = int'(lcg_next() % 4);
            for (int g = 0; g < gap; g++)
            begin
                drive_cycle(1'b0, '0, '0);
            end
            drive_cycle(1'b1, N'(lcg_next()), N'(lcg_next()));
        end
        end_test("gaps");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog/posit_adder.sv */
`timescale 1ns/100ps

module posit_adder #(
    parameter int N = posit_fmt_pkg::POSIT_WIDTH,
    parameter int ES = posit_fmt_pkg::POSIT_ES
) (
    input  logic         aclk,
    input  logic         rst_i,
    input  logic         start_i,
    input  logic [N-1:0] operand_a_i,
    input  logic [N-1:0] operand_b_i,
    output logic [N-1:0] result_o,
    output logic         inf_o,
    output logic         zero_o,
    output logic         done_o
);

    import posit_fmt_pkg::*;

    localparam int SW = scale_width(N, ES);

    // Decoded operands, stage 1
    logic                 sign_a;
    logic                 sign_b;
    logic signed [SW-1:0] scale_a;
    logic signed [SW-1:0] scale_b;
    logic [N-ES-1:0]      frac_a;
    logic [N-ES-1:0]      frac_b;
    logic [N-2:0]         magnitude_a;
    logic [N-2:0]         magnitude_b;

    // Ordered and aligned, stage 3
    logic                 large_sign;
    logic                 effective_sub;
    logic signed [SW-1:0] large_scale;
    logic [N-1:0]         large_frac;
    logic [N-1:0]         small_frac;

    // Normalised sum, stage 5
    logic [N-1:0]         sum_frac;
    logic signed [SW-1:0] sum_scale;
    logic                 sum_nonzero;
    logic                 sum_sign;

    // Packed result, stage 6
    logic [N-1:0]         packed_sum;

    posit_decode #(
        .N(N),
        .ES(ES)
    ) decode_a_i (
        .aclk(aclk),
        .operand_i(operand_a_i),
        .sign_o(sign_a),
        .scale_o(scale_a),
        .frac_o(frac_a),
        .magnitude_o(magnitude_a)
    );

    posit_decode #(
        .N(N),
        .ES(ES)
    ) decode_b_i (
        .aclk(aclk),
        .operand_i(operand_b_i),
        .sign_o(sign_b),
        .scale_o(scale_b),
        .frac_o(frac_b),
        .magnitude_o(magnitude_b)
    );

    operand_align #(
        .N(N),
        .ES(ES)
    ) align_i (
        .aclk(aclk),
        .sign_a_i(sign_a),
        .sign_b_i(sign_b),
        .scale_a_i(scale_a),
        .scale_b_i(scale_b),
        .frac_a_i(frac_a),
        .frac_b_i(frac_b),
        .magnitude_a_i(magnitude_a),
        .magnitude_b_i(magnitude_b),
        .large_sign_o(large_sign),
        .effective_sub_o(effective_sub),
        .large_scale_o(large_scale),
        .large_frac_o(large_frac),
        .small_frac_o(small_frac)
    );

    mantissa_norm #(
        .N(N),
        .ES(ES)
    ) norm_i (
        .aclk(aclk),
        .effective_sub_i(effective_sub),
        .large_scale_i(large_scale),
        .large_frac_i(large_frac),
        .small_frac_i(small_frac),
        .sign_i(large_sign),
        .sum_frac_o(sum_frac),
        .sum_scale_o(sum_scale),
        .sum_nonzero_o(sum_nonzero),
        .sign_o(sum_sign)
    );

    posit_encode #(
        .N(N),
        .ES(ES)
    ) encode_i (
        .aclk(aclk),
        .sum_frac_i(sum_frac),
        .sum_scale_i(sum_scale),
        .sum_nonzero_i(sum_nonzero),
        .sign_i(sum_sign),
        .packed_o(packed_sum)
    );

    // Raw operands go straight in for special-case classification
    pipe_control #(
        .N(N)
    ) control_i (
        .aclk(aclk),
        .rst_i(rst_i),
        .start_i(start_i),
        .operand_a_i(operand_a_i),
        .operand_b_i(operand_b_i),
        .packed_i(packed_sum),
        .result_o(result_o),
        .inf_o(inf_o),
        .zero_o(zero_o),
        .done_o(done_o)
    );

endmodule

/* verilog/pipe_control.sv */
`timescale 1ns/100ps

module pipe_control #(
    parameter int N = posit_fmt_pkg::POSIT_WIDTH
) (
    input  logic         aclk,
    input  logic         rst_i,
    input  logic         start_i,
    input  logic [N-1:0] operand_a_i,
    input  logic [N-1:0] operand_b_i,
    input  logic [N-1:0] packed_i,
    output logic [N-1:0] result_o,
    output logic         inf_o,
    output logic         zero_o,
    output logic         done_o
);

    import pipe_pkg::*;

    logic                  nar_a;
    logic                  nar_b;
    logic                  zero_a;
    logic                  zero_b;
    logic [PIPE_DEPTH-1:0] start_q;
    logic [PIPE_DEPTH-1:0] inf_q;
    logic [PIPE_DEPTH-1:0] zero_q;

    // NaR is sign only, zero is all clear
    assign nar_a  = operand_a_i[N-1] & ~|operand_a_i[N-2:0];
    assign nar_b  = operand_b_i[N-1] & ~|operand_b_i[N-2:0];
    assign zero_a = ~|operand_a_i;
    assign zero_b = ~|operand_b_i;

    // Strobe and flags ride alongside the datapath, one bit per stage
    // Flags qualified by start so idle slots stay clear
    always_ff @(posedge aclk)
    begin
        if (rst_i)
        begin
            start_q <= '0;
            inf_q   <= '0;
            zero_q  <= '0;
        end
        else
        begin
            start_q <= {start_q[PIPE_DEPTH-2:0], start_i};
            inf_q   <= {inf_q[PIPE_DEPTH-2:0], start_i & (nar_a | nar_b)};
            zero_q  <= {zero_q[PIPE_DEPTH-2:0], start_i & zero_a & zero_b};
        end
    end

    assign done_o = start_q[PIPE_DEPTH-1];
    assign inf_o  = inf_q[PIPE_DEPTH-1];
    assign zero_o = zero_q[PIPE_DEPTH-1];

    // Special cases override the packed sum
    // Idle cycles read as zero
    always_comb
    begin
        if (inf_o)
        begin
            result_o = {1'b1, {(N-1){1'b0}}};
        end
        else if (zero_o || !done_o)
        begin
            result_o = '0;
        end
        else
        begin
            result_o = packed_i;
        end
    end

endmodule

/* verilog/posit_encode.sv */
`timescale 1ns/100ps

module posit_encode #(
    parameter int N = posit_fmt_pkg::POSIT_WIDTH,
    parameter int ES = posit_fmt_pkg::POSIT_ES,
    localparam int SW = posit_fmt_pkg::scale_width(N, ES)
) (
    input  logic                 aclk,
    input  logic [N-1:0]         sum_frac_i,
    input  logic signed [SW-1:0] sum_scale_i,
    input  logic                 sum_nonzero_i,
    input  logic                 sign_i,
    output logic [N-1:0]         packed_o
);

    import posit_fmt_pkg::*;

    localparam int RW = regime_width(N);

    logic                 regime_neg;
    logic signed [SW-1:0] regime_k;
    logic [ES-1:0]        exponent;
    logic signed [SW-1:0] run_len;
    logic [RW-1:0]        shift;
    logic [2*N-1:0]       word;
    logic [2*N-1:0]       shifted;
    logic [N-1:0]         magnitude;

    // Floor split, exponent is always the low bits
    assign regime_k   = sum_scale_i >>> ES;
    assign exponent   = sum_scale_i[ES-1:0];
    assign regime_neg = sum_scale_i[SW-1];

    // k+1 ones for k >= 0, -k zeros below that
    assign run_len = regime_neg ? -regime_k : regime_k + SW'(1);

    // Longer runs give maxpos or zero anyway
    assign shift = (run_len > N - 1) ? RW'(N - 1) : run_len[RW-1:0];

    // Run fill on top, then terminator, exponent and fraction without hidden bit
    assign word = {{N{~regime_neg}}, regime_neg, exponent, sum_frac_i[N-2:ES]};

    // Fill bits enter from the top, low bits truncate
    assign shifted = word >> shift;
    assign magnitude = {1'b0, shifted[N-1:1]};

    // Stage 6 (pack)
    always_ff @(posedge aclk)
    begin
        if (!sum_nonzero_i)
        begin
            packed_o <= '0;
        end
        else if (sign_i)
        begin
            packed_o <= -magnitude;
        end
        else
        begin
            packed_o <= magnitude;
        end
    end

endmodule

/* verilog/mantissa_norm.sv */
`timescale 1ns/100ps

module mantissa_norm #(
    parameter int N = posit_fmt_pkg::POSIT_WIDTH,
    parameter int ES = posit_fmt_pkg::POSIT_ES,
    localparam int SW = posit_fmt_pkg::scale_width(N, ES)
) (
    input  logic                 aclk,
    input  logic                 effective_sub_i,
    input  logic signed [SW-1:0] large_scale_i,
    input  logic [N-1:0]         large_frac_i,
    input  logic [N-1:0]         small_frac_i,
    input  logic                 sign_i,
    output logic [N-1:0]         sum_frac_o,
    output logic signed [SW-1:0] sum_scale_o,
    output logic                 sum_nonzero_o,
    output logic                 sign_o
);

    import posit_fmt_pkg::*;

    // Leading-zero count runs up to N+1
    localparam int LZW = regime_width(N) + 1;

    logic [N:0]           s1_sum;
    logic signed [SW-1:0] s1_scale;
    logic                 s1_sign;
    logic [LZW-1:0]       lead_zeros;
    logic                 lead_found;
    logic signed [SW-1:0] lead_zeros_s;
    logic [N:0]           norm_sum;

    // Stage 4 (add), extra top bit keeps the carry
    always_ff @(posedge aclk)
    begin
        if (effective_sub_i)
        begin
            s1_sum <= {1'b0, large_frac_i} - {1'b0, small_frac_i};
        end
        else
        begin
            s1_sum <= {1'b0, large_frac_i} + {1'b0, small_frac_i};
        end
        s1_scale <= large_scale_i;
        s1_sign  <= sign_i;
    end

    // Leading-one detection from the carry bit down
    always_comb
    begin
        lead_zeros = '0;
        lead_found = 1'b0;
        for (int i = N; i >= 0; i--)
        begin
            if (s1_sum[i])
            begin
                lead_found = 1'b1;
            end
            else if (!lead_found)
            begin
                lead_zeros = lead_zeros + 1'b1;
            end
        end
    end

    assign norm_sum = s1_sum << lead_zeros;
    assign lead_zeros_s = {{(SW-LZW){1'b0}}, lead_zeros};

    // Stage 5 (norm)
    // Hidden bit lands on N-1, lowest sum bit dropped
    // Carry adds one to the scale, each leading zero takes one off
    always_ff @(posedge aclk)
    begin
        sum_frac_o    <= norm_sum[N:1];
        sum_scale_o   <= s1_scale + SW'(1) - lead_zeros_s;
        sum_nonzero_o <= lead_found;
        sign_o        <= s1_sign;
    end

endmodule

/* verilog/operand_align.sv */
`timescale 1ns/100ps

module operand_align #(
    parameter int N = posit_fmt_pkg::POSIT_WIDTH,
    parameter int ES = posit_fmt_pkg::POSIT_ES,
    localparam int SW = posit_fmt_pkg::scale_width(N, ES)
) (
    input  logic                 aclk,
    input  logic                 sign_a_i,
    input  logic                 sign_b_i,
    input  logic signed [SW-1:0] scale_a_i,
    input  logic signed [SW-1:0] scale_b_i,
    input  logic [N-ES-1:0]      frac_a_i,
    input  logic [N-ES-1:0]      frac_b_i,
    input  logic [N-2:0]         magnitude_a_i,
    input  logic [N-2:0]         magnitude_b_i,
    output logic                 large_sign_o,
    output logic                 effective_sub_o,
    output logic signed [SW-1:0] large_scale_o,
    output logic [N-1:0]         large_frac_o,
    output logic [N-1:0]         small_frac_o
);

    import posit_fmt_pkg::*;

    localparam int RW = regime_width(N);

    logic                 a_first;
    logic signed [SW-1:0] large_scale;
    logic signed [SW-1:0] small_scale;
    logic signed [SW-1:0] scale_diff;
    logic [RW-1:0]        shift_sat;

    // Stage 2 (order) registers
    logic                 s1_sign;
    logic                 s1_sub;
    logic signed [SW-1:0] s1_scale;
    logic [N-ES-1:0]      s1_large_frac;
    logic [N-ES-1:0]      s1_small_frac;
    logic [RW-1:0]        s1_shift;

    // Body magnitudes order the same way as the values
    assign a_first = magnitude_a_i >= magnitude_b_i;

    assign large_scale = a_first ? scale_a_i : scale_b_i;
    assign small_scale = a_first ? scale_b_i : scale_a_i;

    // Never negative after the swap
    assign scale_diff = large_scale - small_scale;

    // Anything past N-1 already shifts the fraction out
    assign shift_sat = (scale_diff > N - 1) ? RW'(N - 1) : scale_diff[RW-1:0];

    always_ff @(posedge aclk)
    begin
        s1_sign       <= a_first ? sign_a_i : sign_b_i;
        // Differing signs mean the magnitudes subtract
        s1_sub        <= sign_a_i ^ sign_b_i;
        s1_scale      <= large_scale;
        s1_large_frac <= a_first ? frac_a_i : frac_b_i;
        s1_small_frac <= a_first ? frac_b_i : frac_a_i;
        s1_shift      <= shift_sat;
    end

    // Stage 3 (shift) registers
    // ES guard bits padded below both fractions
    always_ff @(posedge aclk)
    begin
        large_sign_o    <= s1_sign;
        effective_sub_o <= s1_sub;
        large_scale_o   <= s1_scale;
        large_frac_o    <= {s1_large_frac, {ES{1'b0}}};
        // Bits shifted out on the right are dropped
        small_frac_o    <= {s1_small_frac, {ES{1'b0}}} >> s1_shift;
    end

endmodule

/* verilog/posit_decode.sv */
`timescale 1ns/100ps

module posit_decode #(
    parameter int N = posit_fmt_pkg::POSIT_WIDTH,
    parameter int ES = posit_fmt_pkg::POSIT_ES,
    localparam int SW = posit_fmt_pkg::scale_width(N, ES)
) (
    input  logic                 aclk,
    input  logic [N-1:0]         operand_i,
    output logic                 sign_o,
    output logic signed [SW-1:0] scale_o,
    output logic [N-ES-1:0]      frac_o,
    output logic [N-2:0]         magnitude_o
);

    import posit_fmt_pkg::*;

    localparam int RW = regime_width(N);

    logic [N-1:0]         body;
    logic                 regime_bit;
    logic [RW-1:0]        run_len;
    logic                 run_end;
    logic [N-2:0]         rest;
    logic signed [SW-1:0] run_s;
    logic signed [SW-1:0] regime_val;
    logic signed [SW-1:0] scale;

    // Negative posits decode from their two's complement
    assign body = operand_i[N-1] ? -operand_i : operand_i;
    assign regime_bit = body[N-2];

    // Regime run length, counted down from just below the sign
    always_comb
    begin
        run_len = '0;
        run_end = 1'b0;
        for (int i = N - 2; i >= 0; i--)
        begin
            if (!run_end && body[i] == regime_bit)
            begin
                run_len = run_len + 1'b1;
            end
            else
            begin
                run_end = 1'b1;
            end
        end
    end

    // Strip run plus terminating bit
    // Exponent sits at the top of what is left, fraction below it
    assign rest = body[N-2:0] << ({1'b0, run_len} + 1'b1);

    // Run of ones gives k = run-1, run of zeros gives k = -run
    assign run_s = {{(SW-RW){1'b0}}, run_len};
    assign regime_val = regime_bit ? run_s - SW'(1) : -run_s;
    assign scale = (regime_val <<< ES) + $signed({{(SW-ES){1'b0}}, rest[N-2 -: ES]});

    // Stage 1 (decode) register
    always_ff @(posedge aclk)
    begin
        sign_o      <= operand_i[N-1];
        scale_o     <= scale;
        // Hidden bit stays clear for a zero body so it adds nothing
        frac_o      <= {|body[N-2:0], rest[N-2-ES:0]};
        magnitude_o <= body[N-2:0];
    end

endmodule

/* verilog/pipe_pkg.sv */
package pipe_pkg;

    // Register stages from operand input to result output
    localparam int PIPE_DEPTH = 6;

    // Stage numbers, counted from the input edge
    localparam int STAGE_DECODE = 1;
    localparam int STAGE_ORDER = 2;
    localparam int STAGE_SHIFT = 3;
    localparam int STAGE_ADD = 4;
    localparam int STAGE_NORM = 5;
    localparam int STAGE_PACK = 6;

endpackage

/* verilog/posit_fmt_pkg.sv */
package posit_fmt_pkg;

    // Default posit format, overridden through the adder parameters
    localparam int POSIT_WIDTH = 8;
    localparam int POSIT_ES = 1;

    // Ceiling of log2, enough bits to count a regime run
    function automatic int regime_width(input int width);
        int bits;
        bits = 0;
        while ((1 << bits) < width)
        begin
            bits = bits + 1;
        end
        return bits;
    endfunction

    // Signed scale: regime times 2^es plus exponent
    // Two spare bits cover the sign and the normalisation swing
    function automatic int scale_width(input int width, input int es);
        return regime_width(width) + es + 2;
    endfunction

endpackage
